// ==== Bender.yml ====
package:
  name: lc3b_operand_stage

dependencies: {}

sources:
  - files:
      - lc3b_pkg.sv
      - lc3b_regfile.sv
      - operand_decode.sv
      - forwarding_unit.sv
      - operand_select.sv
      - operand_stage.sv
  - target: test
    files:
      - tb_operand_stage.sv

// ==== flist.f ====
lc3b_pkg.sv
lc3b_regfile.sv
operand_decode.sv
forwarding_unit.sv
operand_select.sv
operand_stage.sv
tb_operand_stage.sv

// ==== forwarding_unit.sv ====
`timescale 1ns/1ps

module forwarding_unit
(
	input  lc3b_pkg::src_regs_t   srcs,
	input  lc3b_pkg::pending_wr_t ex_mem,
	input  lc3b_pkg::pending_wr_t mem_wb,
	output lc3b_pkg::fwd_sel_t    sel
);

	import lc3b_pkg::*;

	logic same_dest;  // both stages pending on one register

	// newest pending write wins, unused sources never forward
	function automatic fwd_src_e pick_src
	(
		input logic        used,
		input lc3b_reg     num,
		input pending_wr_t em,
		input pending_wr_t mw
	);
		if (!used)
		begin
			return fwd_rf;
		end
		if (em.valid && (em.dest == num))
		begin
			return fwd_ex_mem;
		end
		if (mw.valid && (mw.dest == num))
		begin
			return fwd_mem_wb;
		end
		return fwd_rf;
	endfunction

	always_comb
	begin
		sel.a_src  = pick_src(srcs.sr1_used, srcs.sr1, ex_mem, mem_wb);
		sel.b_src  = pick_src(srcs.sr2_used, srcs.sr2, ex_mem, mem_wb);
		sel.st_src = pick_src(srcs.st_used, srcs.st_reg, ex_mem, mem_wb);
	end

	assign same_dest = ex_mem.valid && mem_wb.valid && (ex_mem.dest == mem_wb.dest);

	// with two writes to one register in flight, the older MEM/WB value is stale
	always_comb
	begin
		if (same_dest)
		begin
			a_ex_mem_first : assert final (
				!(srcs.sr1_used && (srcs.sr1 == ex_mem.dest)) ||
				(sel.a_src == fwd_ex_mem)
			)
			else $error("op_a took a stale MEM/WB value");

			b_ex_mem_first : assert final (
				!(srcs.sr2_used && (srcs.sr2 == ex_mem.dest)) ||
				(sel.b_src == fwd_ex_mem)
			)
			else $error("op_b took a stale MEM/WB value");

			st_ex_mem_first : assert final (
				!(srcs.st_used && (srcs.st_reg == ex_mem.dest)) ||
				(sel.st_src == fwd_ex_mem)
			)
			else $error("store data took a stale MEM/WB value");
		end
	end

endmodule : forwarding_unit

// ==== lc3b_pkg.sv ====
package lc3b_pkg;

	localparam int num_regs = 8;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;

	// LC-3b opcode field, bits 15:12
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001,
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// operate format: add, and, not, shf, jmp
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dr;
		lc3b_reg    sr1;
		logic       imm_flag;  // bit 5
		logic [4:0] imm5;      // low 3 bits double as sr2
	} alu_view_t;

	// base + offset format: loads and stores
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    srdr;      // store data or load destination
		lc3b_reg    base;
		logic [5:0] offset6;
	} mem_view_t;

	typedef union packed {
		alu_view_t alu;
		mem_view_t mem;
	} lc3b_instr_u;

	// one in-flight register write, EX/MEM or MEM/WB
	typedef struct packed {
		logic     valid;
		lc3b_reg  dest;
		lc3b_word val;
	} pending_wr_t;

	// source registers the instruction actually reads
	typedef struct packed {
		logic       sr1_used;
		lc3b_reg    sr1;
		logic       sr2_used;
		lc3b_reg    sr2;
		logic       st_used;
		lc3b_reg    st_reg;
		logic       use_imm;   // op_b comes from imm5
		logic [4:0] imm5;
	} src_regs_t;

	typedef enum logic [1:0] {
		fwd_rf     = 2'd0,
		fwd_ex_mem = 2'd1,
		fwd_mem_wb = 2'd2
	} fwd_src_e;

	typedef struct packed {
		fwd_src_e a_src;
		fwd_src_e b_src;
		fwd_src_e st_src;
	} fwd_sel_t;

	// ID/EX pipeline register contents
	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_word   ir;
		lc3b_word   op_a;
		lc3b_word   op_b;
		lc3b_word   st_data;
	} ex_operands_t;

endpackage : lc3b_pkg

// ==== lc3b_regfile.sv ====
`timescale 1ns/1ps

module lc3b_regfile
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  lc3b_pkg::pending_wr_t wr,          // write port from MEM/WB

	input  lc3b_pkg::lc3b_reg     rd_a_addr,
	input  lc3b_pkg::lc3b_reg     rd_b_addr,
	input  lc3b_pkg::lc3b_reg     rd_st_addr,

	output lc3b_pkg::lc3b_word    rd_a,
	output lc3b_pkg::lc3b_word    rd_b,
	output lc3b_pkg::lc3b_word    rd_st
);

	import lc3b_pkg::*;

	lc3b_word regs [num_regs];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < num_regs; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wr.valid)
		begin
			regs[wr.dest] <= wr.val;
		end
	end

	// reads see stored contents only, a same-cycle write is covered by forwarding
	assign rd_a  = regs[rd_a_addr];
	assign rd_b  = regs[rd_b_addr];
	assign rd_st = regs[rd_st_addr];

	// an unknown destination would corrupt an arbitrary register
	a_wr_dest_known : assert property (
		@(posedge clk) disable iff (!arst_n)
		wr.valid |-> !$isunknown(wr.dest)
	)
	else $error("regfile write with unknown destination");

endmodule : lc3b_regfile

// ==== operand_decode.sv ====
`timescale 1ns/1ps

module operand_decode
(
	input  lc3b_pkg::lc3b_word  ir,
	output lc3b_pkg::src_regs_t srcs
);

	import lc3b_pkg::*;

	lc3b_instr_u instr;

	assign instr = ir;

	always_comb
	begin
		// register numbers always follow the fields so the read ports stay stable
		srcs          = '0;
		srcs.sr1      = instr.alu.sr1;
		srcs.sr2      = instr.alu.imm5[2:0];
		srcs.st_reg   = instr.mem.srdr;
		srcs.imm5     = instr.alu.imm5;

		case (instr.alu.opcode)
			op_add,
			op_and:
			begin
				srcs.sr1_used = 1'b1;
				if (instr.alu.imm_flag)
				begin
					srcs.use_imm = 1'b1;  // immediate form reads no sr2
				end
				else
				begin
					srcs.sr2_used = 1'b1;
				end
			end

			op_jmp,
			op_ldb,
			op_ldi,
			op_ldr,
			op_not,
			op_shf:
			begin
				srcs.sr1_used = 1'b1;
			end

			op_jsr:
			begin
				// jsrr (bit 11 clear) jumps through base
				srcs.sr1_used = ~ir[11];
			end

			op_stb,
			op_sti,
			op_str:
			begin
				srcs.sr1_used = 1'b1;  // base shares bits 8:6 with sr1
				srcs.st_used  = 1'b1;  // srdr holds the data to store
			end

			default:
			begin
				// br, lea, rti, trap read no register
				srcs.sr1_used = 1'b0;
			end
		endcase
	end

endmodule : operand_decode

// ==== operand_select.sv ====
`timescale 1ns/1ps

module operand_select
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   id_valid,
	input  lc3b_pkg::lc3b_word     ir,
	input  lc3b_pkg::src_regs_t    srcs,
	input  lc3b_pkg::fwd_sel_t     sel,
	input  lc3b_pkg::pending_wr_t  ex_mem,
	input  lc3b_pkg::pending_wr_t  mem_wb,
	input  lc3b_pkg::lc3b_word     rd_a,
	input  lc3b_pkg::lc3b_word     rd_b,
	input  lc3b_pkg::lc3b_word     rd_st,
	output logic                   ex_valid,
	output lc3b_pkg::ex_operands_t ex_ops
);

	import lc3b_pkg::*;

	lc3b_word     imm_sext;
	ex_operands_t ops_next;

	function automatic lc3b_word fwd_value
	(
		input fwd_src_e src,
		input lc3b_word rf_val,
		input lc3b_word em_val,
		input lc3b_word mw_val
	);
		case (src)
			fwd_ex_mem: return em_val;
			fwd_mem_wb: return mw_val;
			default:    return rf_val;
		endcase
	endfunction

	assign imm_sext = {{11{srcs.imm5[4]}}, srcs.imm5};

	always_comb
	begin
		ops_next.opcode  = lc3b_opcode'(ir[15:12]);
		ops_next.ir      = ir;
		ops_next.op_a    = fwd_value(sel.a_src, rd_a, ex_mem.val, mem_wb.val);
		ops_next.op_b    = srcs.use_imm ? imm_sext
			: fwd_value(sel.b_src, rd_b, ex_mem.val, mem_wb.val);
		ops_next.st_data = fwd_value(sel.st_src, rd_st, ex_mem.val, mem_wb.val);
	end

	// ID/EX register, payload holds while no instruction arrives
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ex_valid <= 1'b0;
			ex_ops   <= '0;
		end
		else
		begin
			ex_valid <= id_valid;
			if (id_valid)
			begin
				ex_ops <= ops_next;
			end
		end
	end

	a_ex_valid_known : assert property (
		@(posedge clk) disable iff (!arst_n)
		!$isunknown(ex_valid)
	)
	else $error("ex_valid unknown after reset");

endmodule : operand_select

// ==== operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage
(
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   id_valid,    // instruction present in ID
	input  lc3b_pkg::lc3b_word     id_ir,
	input  lc3b_pkg::pending_wr_t  ex_mem,
	input  lc3b_pkg::pending_wr_t  mem_wb,      // also the regfile write port
	output logic                   ex_valid,
	output lc3b_pkg::ex_operands_t ex_ops
);

	import lc3b_pkg::*;

	src_regs_t srcs;
	fwd_sel_t  sel;
	lc3b_word  rd_a;
	lc3b_word  rd_b;
	lc3b_word  rd_st;

	operand_decode decode_i
	(
		.ir   (id_ir),
		.srcs (srcs)
	);

	lc3b_regfile regfile_i
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.wr         (mem_wb),
		.rd_a_addr  (srcs.sr1),
		.rd_b_addr  (srcs.sr2),
		.rd_st_addr (srcs.st_reg),
		.rd_a       (rd_a),
		.rd_b       (rd_b),
		.rd_st      (rd_st)
	);

	forwarding_unit fwd_i
	(
		.srcs   (srcs),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.sel    (sel)
	);

	operand_select select_i
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.id_valid (id_valid),
		.ir       (id_ir),
		.srcs     (srcs),
		.sel      (sel),
		.ex_mem   (ex_mem),
		.mem_wb   (mem_wb),
		.rd_a     (rd_a),
		.rd_b     (rd_b),
		.rd_st    (rd_st),
		.ex_valid (ex_valid),
		.ex_ops   (ex_ops)
	);

endmodule : operand_stage

// ==== tb_operand_stage.sv ====
`timescale 1ns/1ps

module tb_operand_stage;

	import lc3b_pkg::*;

	localparam int wait_limit   = 8;     // cycles allowed for ex_valid to rise
	localparam int random_count = 2000;

	logic         clk;
	logic         arst_n;
	logic         id_valid;
	lc3b_word     id_ir;
	pending_wr_t  ex_mem;
	pending_wr_t  mem_wb;
	logic         ex_valid;
	ex_operands_t ex_ops;

	// reference model state
	lc3b_word     shadow [num_regs];
	logic         exp_valid;
	ex_operands_t exp_ops;

	integer       seed;
	pending_wr_t  no_wr;

	operand_stage dut_i
	(
		.clk      (clk),
		.arst_n   (arst_n),
		.id_valid (id_valid),
		.id_ir    (id_ir),
		.ex_mem   (ex_mem),
		.mem_wb   (mem_wb),
		.ex_valid (ex_valid),
		.ex_ops   (ex_ops)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string name, input lc3b_word expv, input lc3b_word actv);
		abort_run($sformatf("Fail %s expected %h actual %h", name, expv, actv));
	endtask

	function automatic pending_wr_t make_write(input logic v, input lc3b_reg d, input lc3b_word x);
		pending_wr_t w;
		w.valid = v;
		w.dest  = d;
		w.val   = x;
		return w;
	endfunction

	// newest pending value of a register that is read, else the stored one
	function automatic lc3b_word newest(input logic used, input lc3b_reg r,
		input pending_wr_t em, input pending_wr_t mw);
		if (used && em.valid && (em.dest == r))
		begin
			return em.val;
		end
		if (used && mw.valid && (mw.dest == r))
		begin
			return mw.val;
		end
		return shadow[r];
	endfunction

	function automatic ex_operands_t expected_ops(input lc3b_word ir,
		input pending_wr_t em, input pending_wr_t mw);
		ex_operands_t e;
		lc3b_opcode   op;
		logic         a_used;
		logic         b_used;
		logic         imm;
		logic         st_used;
		op      = lc3b_opcode'(ir[15:12]);
		a_used  = (op inside {op_add, op_and, op_jmp, op_ldb, op_ldi, op_ldr, op_not, op_shf,
			op_stb, op_sti, op_str}) || ((op == op_jsr) && !ir[11]);
		imm     = (op inside {op_add, op_and}) && ir[5];
		b_used  = (op inside {op_add, op_and}) && !ir[5];
		st_used = op inside {op_stb, op_sti, op_str};
		e.opcode  = op;
		e.ir      = ir;
		e.op_a    = newest(a_used, ir[8:6], em, mw);   // sr1 or store base
		e.op_b    = imm ? {{11{ir[4]}}, ir[4:0]} : newest(b_used, ir[2:0], em, mw);
		e.st_data = newest(st_used, ir[11:9], em, mw);
		return e;
	endfunction

	// expected ID/EX contents, shadow file read before this edge's write lands
	always @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			exp_valid <= 1'b0;
			exp_ops   <= '0;
			for (int i = 0; i < num_regs; i++)
			begin
				shadow[i] <= '0;
			end
		end
		else
		begin
			exp_valid <= id_valid;
			if (id_valid)
			begin
				exp_ops <= expected_ops(id_ir, ex_mem, mem_wb);
			end
			if (mem_wb.valid)
			begin
				shadow[mem_wb.dest] <= mem_wb.val;
			end
		end
	end

	a_valid : assert property (@(posedge clk) disable iff (!arst_n) ex_valid == exp_valid)
		else report_mismatch("ex_valid", $sampled(exp_valid), $sampled(ex_valid));
	a_ir : assert property (@(posedge clk) disable iff (!arst_n) ex_ops.ir == exp_ops.ir)
		else report_mismatch("ex_ops.ir", $sampled(exp_ops.ir), $sampled(ex_ops.ir));
	a_opcode : assert property (@(posedge clk) disable iff (!arst_n)
		ex_ops.opcode == exp_ops.opcode)
		else report_mismatch("ex_ops.opcode", $sampled(exp_ops.opcode), $sampled(ex_ops.opcode));
	a_op_a : assert property (@(posedge clk) disable iff (!arst_n) ex_ops.op_a == exp_ops.op_a)
		else report_mismatch("ex_ops.op_a", $sampled(exp_ops.op_a), $sampled(ex_ops.op_a));
	a_op_b : assert property (@(posedge clk) disable iff (!arst_n) ex_ops.op_b == exp_ops.op_b)
		else report_mismatch("ex_ops.op_b", $sampled(exp_ops.op_b), $sampled(ex_ops.op_b));
	a_st_data : assert property (@(posedge clk) disable iff (!arst_n)
		ex_ops.st_data == exp_ops.st_data)
		else report_mismatch("ex_ops.st_data", $sampled(exp_ops.st_data),
			$sampled(ex_ops.st_data));
	a_hold : assert property (@(posedge clk) disable iff (!arst_n)
		!$past(id_valid) |-> $stable(ex_ops))
		else abort_run("ex_ops changed in a cycle after no instruction was issued");

	task automatic drive_cycle(input logic v, input lc3b_word ir,
		input pending_wr_t em, input pending_wr_t mw);
		@(posedge clk);
		id_valid <= v;
		id_ir    <= ir;
		ex_mem   <= em;
		mem_wb   <= mw;
	endtask

	// single instruction, then wait for it to reach ID/EX
	task automatic issue_and_wait(input lc3b_word ir, input pending_wr_t em, input pending_wr_t mw);
		int cycles;
		cycles = 0;
		drive_cycle(1'b1, ir, em, mw);
		drive_cycle(1'b0, 16'h0000, no_wr, no_wr);
		@(negedge clk);
		while (!ex_valid && (cycles < wait_limit))
		begin
			@(negedge clk);
			cycles++;
		end
		if (!ex_valid)
		begin
			abort_run("timed out waiting for ex_valid after an issued instruction");
		end
	endtask

	initial
	begin
		seed     = 83808;
		no_wr    = '0;
		arst_n   = 1'b0;
		id_valid = 1'b0;
		id_ir    = '0;
		ex_mem   = '0;
		mem_wb   = '0;
		repeat (2) @(posedge clk);
		arst_n <= 1'b1;

		// all registers read zero after reset
		for (int i = 0; i < num_regs; i++)
		begin
			issue_and_wait({op_add, 3'd0, 3'(i), 1'b0, 2'b00, 3'(7 - i)}, no_wr, no_wr);
		end

		for (int i = 0; i < num_regs; i++)  // fill the file through MEM/WB
		begin
			drive_cycle(1'b0, 16'h0000, no_wr, make_write(1'b1, 3'(i), 16'($random(seed))));
		end
		drive_cycle(1'b1, {op_add, 3'd1, 3'd2, 1'b0, 2'b00, 3'd5}, no_wr, no_wr);
		drive_cycle(1'b1, {op_and, 3'd7, 3'd0, 1'b0, 2'b00, 3'd6}, no_wr, no_wr);
		drive_cycle(1'b1, {op_ldr, 3'd4, 3'd6, 6'h3f}, no_wr, no_wr);
		drive_cycle(1'b0, 16'h0000, no_wr, make_write(1'b1, 3'd3, 16'hbeef));
		drive_cycle(1'b1, {op_add, 3'd1, 3'd3, 1'b0, 2'b00, 3'd3}, no_wr, no_wr);

		// forwarding priority on r2
		drive_cycle(1'b1, {op_add, 3'd1, 3'd2, 1'b0, 2'b00, 3'd2},
			make_write(1'b1, 3'd2, 16'haaaa), make_write(1'b1, 3'd2, 16'h5555));
		drive_cycle(1'b1, {op_add, 3'd1, 3'd2, 1'b0, 2'b00, 3'd2},
			no_wr, make_write(1'b1, 3'd2, 16'h7777));
		drive_cycle(1'b1, {op_and, 3'd1, 3'd2, 1'b0, 2'b00, 3'd2},
			make_write(1'b0, 3'd2, 16'h1234), make_write(1'b0, 3'd2, 16'h4321));

		// immediate forms and instructions without a forwarded operand
		drive_cycle(1'b1, {op_add, 3'd1, 3'd2, 1'b1, 5'h13}, make_write(1'b1, 3'd3, 16'h0f0f), no_wr);
		drive_cycle(1'b1, {op_and, 3'd1, 3'd2, 1'b1, 5'h0a}, no_wr, make_write(1'b1, 3'd2, 16'h2468));
		drive_cycle(1'b1, {op_jsr, 1'b1, 11'h0c5}, make_write(1'b1, 3'd3, 16'h3333), no_wr);
		drive_cycle(1'b1, {op_br, 3'b111, 9'h0c5},
			make_write(1'b1, 3'd3, 16'h4444), make_write(1'b1, 3'd5, 16'h5555));
		drive_cycle(1'b1, {op_jsr, 1'b0, 2'b00, 3'd3, 6'h00}, make_write(1'b1, 3'd3, 16'h6666), no_wr);

		// stores forward base and data independently
		drive_cycle(1'b1, {op_stb, 3'd4, 3'd6, 6'h01},
			make_write(1'b1, 3'd6, 16'h1111), make_write(1'b1, 3'd4, 16'h2222));
		drive_cycle(1'b1, {op_str, 3'd4, 3'd6, 6'h02},
			make_write(1'b1, 3'd4, 16'h3333), make_write(1'b1, 3'd6, 16'h4444));
		drive_cycle(1'b1, {op_sti, 3'd5, 3'd5, 6'h03},
			make_write(1'b1, 3'd5, 16'h8888), make_write(1'b1, 3'd5, 16'h9999));
		drive_cycle(1'b1, {op_str, 3'd0, 3'd1, 6'h00}, no_wr, no_wr);

		// idle cycles keep the last payload
		drive_cycle(1'b0, 16'hffff, make_write(1'b1, 3'd1, 16'hdead), no_wr);
		drive_cycle(1'b0, 16'h1234, no_wr, make_write(1'b1, 3'd0, 16'hcafe));
		issue_and_wait({op_not, 3'd2, 3'd0, 6'h3f}, no_wr, no_wr);

		repeat (random_count)
		begin
			drive_cycle(($random(seed) & 3) != 0, 16'($random(seed)),
				make_write(1'($random(seed)), 3'($random(seed)), 16'($random(seed))),
				make_write(1'($random(seed)), 3'($random(seed)), 16'($random(seed))));
		end

		issue_and_wait({op_add, 3'd0, 3'd1, 1'b0, 2'b00, 3'd2}, no_wr, no_wr);
		@(negedge clk);  // let the last result pass its check
		$display("RESULT: PASS");
		$finish;
	end

endmodule : tb_operand_stage
